//--- include/sd_reg_defs.svh
/*
 * SD host register block constants
 * Bus widths, register offsets, field positions and reset values
 * shared by the register RTL and its testbench
 */

`ifndef SD_REG_DEFS_SVH
`define SD_REG_DEFS_SVH

// ========================================
// Bus widths
// ========================================
`define SD_ADDR_W           16          // Register bus address
`define SD_DATA_W           32          // Register bus data
`define SD_RESP_W           40          // Short command response

// ========================================
// Register offsets
// ========================================
`define SD_CTRL_ADDR        16'h0000
`define SD_STATUS_ADDR      16'h0004    // Read-only
`define SD_CMD_ADDR         16'h0008
`define SD_ARG_ADDR         16'h000C
`define SD_RESP0_ADDR       16'h0010    // Read-only
`define SD_RESP1_ADDR       16'h0014    // Read-only
`define SD_CLK_DIV_ADDR     16'h0030
`define SD_INT_EN_ADDR      16'h0034
`define SD_INT_STAT_ADDR    16'h0038    // Read-only
`define SD_SEC_CTRL_ADDR    16'h0044    // Needs access_granted
`define SD_VERSION_ADDR     16'h005C    // Read-only

// ========================================
// Field positions and widths
// ========================================
`define SD_CTRL_CLK_EN_BIT  14          // SD clock enable in CTRL
`define SD_CMD_START_BIT    31          // Command start in CMD
`define SD_CMD_INDEX_W      6           // Command index, CMD[5:0]
`define SD_CLK_DIV_W        16          // Divider, CLK_DIV[15:0]
`define SD_INT_W            4           // Interrupt lines

// ========================================
// Reset and constant values
// ========================================
`define SD_CLK_DIV_RST      32'h0000_007F   // Identification speed
`define SD_VERSION_VAL      32'h0100_0000

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the SD register block testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sd_reg_file.f --top-module tb_sd_reg_top -o tb_sd_reg_top \
    && ./obj_dir/tb_sd_reg_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Simulation completed successfully$" sim.log \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }
exit 0

//--- sd_reg_file.f
+incdir+include
src/sd_regmap_pkg.sv
src/sd_link_pkg.sv
src/sd_reg_access.sv
src/sd_ctrl_regs.sv
src/sd_status_regs.sv
src/sd_reg_top.sv
sim/tb_sd_reg_top.sv

//--- sim/tb_sd_reg_top.sv
/*
 * SD host register block testbench
 * LFSR-driven bus traffic and engine status, checked against a
 * register model kept here, with a watchdog on the whole run
 */

`timescale 1ns/1ps
`default_nettype none

`include "sd_reg_defs.svh"

module tb_sd_reg_top;

    import sd_link_pkg::*;
    import sd_regmap_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 5;
    localparam int RESET_CYCLES = 4;
    localparam int N_RAND       = 32;
    localparam int N_STAT       = 16;
    localparam int N_B2B        = 24;
    localparam int NUM_TXN      = 3 * N_RAND + 5 * N_STAT + 3 * N_B2B + 100;
    localparam int WATCHDOG_NS  = NUM_TXN * 2 * CLK_PERIOD + 20 * CLK_PERIOD;

    localparam logic [15:0] WR_ADDRS [6] = '{`SD_CTRL_ADDR, `SD_CMD_ADDR, `SD_ARG_ADDR,
        `SD_CLK_DIV_ADDR, `SD_INT_EN_ADDR, `SD_SEC_CTRL_ADDR};
    localparam logic [15:0] RO_ADDRS [5] = '{`SD_STATUS_ADDR, `SD_RESP0_ADDR,
        `SD_RESP1_ADDR, `SD_INT_STAT_ADDR, `SD_VERSION_ADDR};

    logic                       PCLK_i;
    logic                       PRESETn_i;
    logic [`SD_ADDR_W-1:0]      reg_addr;
    logic [`SD_DATA_W-1:0]      reg_wdata;
    logic                       reg_read;
    logic                       reg_write;
    logic [`SD_DATA_W-1:0]      reg_rdata;
    logic                       reg_ready;
    logic                       reg_error;
    logic                       access_granted;
    logic                       security_lock;
    cmd_status_t                cmd_status;
    logic                       clk_calibrated;
    cmd_ctrl_t                  cmd_ctrl;
    clk_ctrl_t                  clk_ctrl;
    logic [`SD_INT_W-1:0]       interrupt_status;
    logic [`SD_INT_W-1:0]       interrupt_enable;
    logic [`SD_INT_W-1:0]       interrupt_pending;

    // Reference model state
    logic [31:0]    m_ctrl;
    logic [31:0]    m_cmd;
    logic [31:0]    m_arg;
    logic [31:0]    m_clk_div;
    logic [31:0]    m_int_en;
    logic [31:0]    m_sec;
    logic [31:0]    m_resp0;
    logic [31:0]    m_resp1;
    logic           exp_ready;
    logic           exp_error;
    logic [31:0]    exp_rdata;
    logic [15:0]    lfsr_state;

    sd_reg_top i_sd_reg_top (
        .PCLK_i            (PCLK_i),
        .PRESETn_i         (PRESETn_i),
        .reg_addr          (reg_addr),
        .reg_wdata         (reg_wdata),
        .reg_read          (reg_read),
        .reg_write         (reg_write),
        .reg_rdata         (reg_rdata),
        .reg_ready         (reg_ready),
        .reg_error         (reg_error),
        .access_granted    (access_granted),
        .security_lock     (security_lock),
        .cmd_status        (cmd_status),
        .clk_calibrated    (clk_calibrated),
        .cmd_ctrl          (cmd_ctrl),
        .clk_ctrl          (clk_ctrl),
        .interrupt_status  (interrupt_status),
        .interrupt_enable  (interrupt_enable),
        .interrupt_pending (interrupt_pending)
    );

    always #(CLK_PERIOD / 2) PCLK_i = ~PCLK_i;

    // ========================================
    // Random numbers
    // ========================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // x^16+x^14+x^13+x^11+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // ========================================
    // Reference model
    // ========================================
    function automatic logic is_mapped(input logic [15:0] a);
        return a inside {WR_ADDRS, RO_ADDRS};
    endfunction

    function automatic logic is_read_only(input logic [15:0] a);
        return a inside {RO_ADDRS};
    endfunction

    function automatic logic [31:0] model_read(input logic [15:0] a);
        status_word_t sw;
        sw = {18'h0, cmd_status.busy, cmd_status.done, cmd_status.timeout,
              cmd_status.crc_error, 8'h0, clk_calibrated, 1'b0};
        case (a)
            `SD_CTRL_ADDR:     return m_ctrl;
            `SD_STATUS_ADDR:   return sw;
            `SD_CMD_ADDR:      return m_cmd;
            `SD_ARG_ADDR:      return m_arg;
            `SD_RESP0_ADDR:    return m_resp0;
            `SD_RESP1_ADDR:    return m_resp1;
            `SD_CLK_DIV_ADDR:  return m_clk_div;
            `SD_INT_EN_ADDR:   return m_int_en;
            `SD_INT_STAT_ADDR: return {{(32 - `SD_INT_W){1'b0}}, interrupt_status};
            `SD_SEC_CTRL_ADDR: return m_sec;
            `SD_VERSION_ADDR:  return `SD_VERSION_VAL;
            default:           return '0;
        endcase
    endfunction

    task automatic model_write(input logic [15:0] a, input logic [31:0] d);
        case (a)
            `SD_CTRL_ADDR:     m_ctrl    = d;
            `SD_CMD_ADDR:      m_cmd     = d;
            `SD_ARG_ADDR:      m_arg     = d;
            `SD_CLK_DIV_ADDR:  m_clk_div = d;
            `SD_INT_EN_ADDR:   m_int_en  = d;
            `SD_SEC_CTRL_ADDR: m_sec     = d;
            default: ;
        endcase
    endtask

    // ========================================
    // Checks
    // ========================================
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("FAIL time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
        $display("Simulation failed");
        $fatal(1, "Stopping at first mismatch");
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) report_mismatch(name, {32'h0, got}, {32'h0, exp});
    endtask

    task automatic check_resp(input logic got_rdy, input logic got_err,
                              input logic exp_rdy, input logic exp_err);
        if (got_rdy !== exp_rdy || got_err !== exp_err)
            report_mismatch("reg_ready,reg_error", {62'h0, got_rdy, got_err},
                            {62'h0, exp_rdy, exp_err});
    endtask

    task automatic check_cmd(input cmd_ctrl_t got, input cmd_ctrl_t exp);
        if (got !== exp) report_mismatch("cmd_ctrl", {25'h0, got}, {25'h0, exp});
    endtask

    task automatic check_clk(input clk_ctrl_t got, input clk_ctrl_t exp);
        if (got !== exp) report_mismatch("clk_ctrl", {47'h0, got}, {47'h0, exp});
    endtask

    task automatic check_outputs();
        cmd_ctrl_t exp_cmd;
        clk_ctrl_t exp_clk;
        exp_cmd.start    = m_cmd[`SD_CMD_START_BIT];
        exp_cmd.index    = m_cmd[`SD_CMD_INDEX_W-1:0];
        exp_cmd.argument = m_arg;
        exp_clk.enable   = m_ctrl[`SD_CTRL_CLK_EN_BIT];
        exp_clk.divider  = m_clk_div[`SD_CLK_DIV_W-1:0];
        check_cmd(cmd_ctrl, exp_cmd);
        check_clk(clk_ctrl, exp_clk);
        check_word("interrupt_enable", {28'h0, interrupt_enable}, {28'h0, m_int_en[3:0]});
        check_word("security_lock", {31'h0, security_lock}, {31'h0, m_sec[0]});
    endtask

    // ========================================
    // Bus driver
    // ========================================
    task automatic issue(input logic wr, input logic [15:0] addr, input logic [31:0] data);
        logic err;
        logic ok;
        err = (addr == `SD_SEC_CTRL_ADDR && !access_granted) || (wr && is_read_only(addr));
        ok  = is_mapped(addr) && !err;
        exp_ready = ok;
        exp_error = err;
        exp_rdata = (ok && !wr) ? model_read(addr) : '0;   // Value before this write
        if (ok && wr) model_write(addr, data);
        reg_addr  = addr;
        reg_wdata = data;
        reg_read  = !wr;
        reg_write = wr;
    endtask

    // One cycle; checks the answer to the request sampled at this edge
    task automatic tick();
        @(posedge PCLK_i);
        #(DRIVE_DLY);
        check_resp(reg_ready, reg_error, exp_ready, exp_error);
        check_word("reg_rdata", reg_rdata, exp_rdata);
        exp_ready = 1'b0;
        exp_error = 1'b0;
        exp_rdata = '0;
        reg_read  = 1'b0;
        reg_write = 1'b0;
    endtask

    task automatic drive_status();
        cmd_status.busy      = rand_bits(1) == 1;
        cmd_status.done      = rand_bits(1) == 1;
        cmd_status.timeout   = rand_bits(1) == 1;
        cmd_status.crc_error = rand_bits(1) == 1;
        cmd_status.response  = {8'(rand_bits(8)), rand_bits(32)};
        clk_calibrated       = rand_bits(1) == 1;
        interrupt_status     = 4'(rand_bits(4));
        if (cmd_status.done) begin                         // Loads at the next edge
            m_resp0 = {8'h00, cmd_status.response[39:16]};
            m_resp1 = {cmd_status.response[15:0], 16'h0000};
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        logic [15:0]            a;
        logic [31:0]            d;
        logic [`SD_INT_W-1:0]   prev_int;
        PCLK_i = 1'b0;
        PRESETn_i = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        reg_read = 1'b0;
        reg_write = 1'b0;
        access_granted = 1'b1;
        cmd_status = '0;
        clk_calibrated = 1'b0;
        interrupt_status = '0;
        lfsr_state = 16'd27224;
        {m_ctrl, m_cmd, m_arg, m_int_en, m_sec, m_resp0, m_resp1} = '0;
        m_clk_div = `SD_CLK_DIV_RST;
        exp_ready = 1'b0;
        exp_error = 1'b0;
        exp_rdata = '0;

        repeat (RESET_CYCLES) tick();
        PRESETn_i = 1'b1;
        tick();

        // Reset values
        foreach (WR_ADDRS[i]) begin
            issue(1'b0, WR_ADDRS[i], '0);
            tick();
        end
        foreach (RO_ADDRS[i]) begin
            issue(1'b0, RO_ADDRS[i], '0);
            tick();
        end
        check_outputs();

        // Random write then read of writable registers
        for (int n = 0; n < N_RAND; n++) begin
            a = WR_ADDRS[int'(rand_bits(3) % 32'd6)];
            d = rand_bits(32);
            issue(1'b1, a, d);
            tick();
            issue(1'b0, a, '0);
            tick();
            tick();
            check_outputs();
        end

        // Security control with and without access
        for (int n = 0; n < 4; n++) begin
            access_granted = 1'b0;
            issue(1'b1, `SD_SEC_CTRL_ADDR, rand_bits(32));
            tick();
            issue(1'b0, `SD_SEC_CTRL_ADDR, '0);
            tick();
            access_granted = 1'b1;
            issue(1'b0, `SD_SEC_CTRL_ADDR, '0);            // Still the old value
            tick();
            issue(1'b1, `SD_SEC_CTRL_ADDR, rand_bits(32));
            tick();
            issue(1'b0, `SD_SEC_CTRL_ADDR, '0);
            tick();
            tick();
            check_outputs();
        end

        // Read-only registers refuse writes
        foreach (RO_ADDRS[i]) begin
            issue(1'b1, RO_ADDRS[i], rand_bits(32));
            tick();
            issue(1'b0, RO_ADDRS[i], '0);
            tick();
        end

        // Unmapped addresses stay silent
        for (int n = 0; n < 8; n++) begin
            a = 16'(rand_bits(16));
            while (is_mapped(a)) a = 16'(rand_bits(16));
            issue(n[0], a, rand_bits(32));
            tick();
        end

        // Engine status, response capture and interrupts
        for (int n = 0; n < N_STAT; n++) begin
            prev_int = interrupt_status;
            drive_status();
            check_word("interrupt_pending", {28'h0, interrupt_pending}, {28'h0, prev_int});
            issue(1'b0, `SD_STATUS_ADDR, '0);
            tick();
            check_word("interrupt_pending", {28'h0, interrupt_pending},
                       {28'h0, interrupt_status});
            issue(1'b0, `SD_INT_STAT_ADDR, '0);
            tick();
            cmd_status.done     = 1'b0;                    // New response must not load
            cmd_status.response = {8'(rand_bits(8)), rand_bits(32)};
            issue(1'b0, `SD_RESP0_ADDR, '0);
            tick();
            issue(1'b0, `SD_RESP1_ADDR, '0);
            tick();
            tick();
        end

        // Back-to-back traffic
        for (int n = 0; n < N_B2B; n++) begin
            access_granted = 1'b1;
            a = WR_ADDRS[int'(rand_bits(3) % 32'd6)];
            issue(1'b1, a, rand_bits(32));
            tick();
            issue(1'b0, a, '0);
            tick();
            access_granted = rand_bits(1) == 1;
            if (rand_bits(1) == 1)
                issue(1'b1, WR_ADDRS[int'(rand_bits(3) % 32'd6)], rand_bits(32));
            else
                issue(1'b0, RO_ADDRS[int'(rand_bits(3) % 32'd5)], '0);
            tick();
        end
        tick();
        check_outputs();

        $display("Simulation completed successfully");
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the test sequence finished");
        $display("Simulation failed");
        $fatal(1, "Timeout");
    end

endmodule

`default_nettype wire

//--- src/sd_ctrl_regs.sv
/*
 * SD writable control registers
 * Control, command, argument, clock divider, interrupt enable and
 * security control, plus the engine and clock outputs derived from them
 */

`timescale 1ns/1ps
`default_nettype none

`include "sd_reg_defs.svh"

module sd_ctrl_regs (
    input  wire logic                           PCLK_i,
    input  wire logic                           PRESETn_i,
    input  wire sd_regmap_pkg::reg_access_t     acc,
    output logic [`SD_DATA_W-1:0]               rdata,
    output sd_link_pkg::cmd_ctrl_t              cmd_ctrl,
    output sd_link_pkg::clk_ctrl_t              clk_ctrl,
    output logic [`SD_INT_W-1:0]                interrupt_enable,
    output logic                                security_lock
);

    import sd_regmap_pkg::*;

    logic [`SD_DATA_W-1:0]      ctrl_q;
    logic [`SD_DATA_W-1:0]      cmd_q;
    logic [`SD_DATA_W-1:0]      arg_q;
    logic [`SD_DATA_W-1:0]      clk_div_q;
    logic [`SD_DATA_W-1:0]      int_en_q;
    logic [`SD_DATA_W-1:0]      sec_ctrl_q;

    // ========================================
    // Register writes
    // ========================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            ctrl_q     <= '0;
            cmd_q      <= '0;
            arg_q      <= '0;
            clk_div_q  <= `SD_CLK_DIV_RST;         // Start slow for card init
            int_en_q   <= '0;
            sec_ctrl_q <= '0;
        end else if (acc.wr) begin
            case (acc.sel)
                SEL_CTRL:     ctrl_q     <= acc.wdata;
                SEL_CMD:      cmd_q      <= acc.wdata;
                SEL_ARG:      arg_q      <= acc.wdata;
                SEL_CLK_DIV:  clk_div_q  <= acc.wdata;
                SEL_INT_EN:   int_en_q   <= acc.wdata;
                SEL_SEC_CTRL: sec_ctrl_q <= acc.wdata;
                default: ;                          // Not held here
            endcase
        end
    end

    // ========================================
    // Read-back
    // ========================================
    always_comb begin
        case (acc.sel)
            SEL_CTRL:     rdata = ctrl_q;
            SEL_CMD:      rdata = cmd_q;
            SEL_ARG:      rdata = arg_q;
            SEL_CLK_DIV:  rdata = clk_div_q;
            SEL_INT_EN:   rdata = int_en_q;
            SEL_SEC_CTRL: rdata = sec_ctrl_q;
            default:      rdata = '0;               // Status block answers
        endcase
    end

    // ========================================
    // Derived outputs
    // ========================================
    assign cmd_ctrl = '{
        start:    cmd_q[`SD_CMD_START_BIT],
        index:    cmd_q[`SD_CMD_INDEX_W-1:0],
        argument: arg_q
    };

    assign clk_ctrl = '{
        enable:  ctrl_q[`SD_CTRL_CLK_EN_BIT],
        divider: clk_div_q[`SD_CLK_DIV_W-1:0]
    };

    assign interrupt_enable = int_en_q[`SD_INT_W-1:0];
    assign security_lock    = sec_ctrl_q[0];    // Lock bit

    // No command may be launched while the block is held in reset
    a_no_start_in_reset: assert property (
        @(posedge PCLK_i) !PRESETn_i |-> !cmd_ctrl.start
    );

endmodule

`default_nettype wire

//--- src/sd_link_pkg.sv
/*
 * SD host link types
 * Control and status bundles between the register block, the
 * command engine and the SD clock generator
 */

`default_nettype none

`include "sd_reg_defs.svh"

package sd_link_pkg;

    // ========================================
    // Command engine
    // ========================================
    typedef struct packed {
        logic                           start;      // Kick off a command
        logic [`SD_CMD_INDEX_W-1:0]     index;      // CMD0..CMD63
        logic [`SD_DATA_W-1:0]          argument;
    } cmd_ctrl_t;

    typedef struct packed {
        logic                           busy;
        logic                           done;       // One-cycle pulse
        logic                           timeout;
        logic                           crc_error;
        logic [`SD_RESP_W-1:0]          response;   // Valid with done
    } cmd_status_t;

    // ========================================
    // Clock generator
    // ========================================
    typedef struct packed {
        logic                           enable;     // Gate SD clock out
        logic [`SD_CLK_DIV_W-1:0]       divider;
    } clk_ctrl_t;

endpackage

`default_nettype wire

//--- src/sd_reg_access.sv
/*
 * SD register bus front end
 * Captures each read or write strobe, decodes the address, applies
 * the security and write-protect rules and answers one cycle later
 */

`timescale 1ns/1ps
`default_nettype none

`include "sd_reg_defs.svh"

module sd_reg_access (
    input  wire logic                       PCLK_i,
    input  wire logic                       PRESETn_i,
    input  wire logic [`SD_ADDR_W-1:0]      reg_addr,
    input  wire logic [`SD_DATA_W-1:0]      reg_wdata,
    input  wire logic                       reg_read,
    input  wire logic                       reg_write,
    input  wire logic                       access_granted,
    input  wire logic [`SD_DATA_W-1:0]      ctrl_rdata,
    input  wire logic [`SD_DATA_W-1:0]      status_rdata,
    output sd_regmap_pkg::reg_access_t      acc,
    output logic [`SD_DATA_W-1:0]           reg_rdata,
    output logic                            reg_ready,
    output logic                            reg_error
);

    import sd_regmap_pkg::*;

    reg_sel_e                   sel_d;
    logic                       read_only;
    logic                       req;
    logic                       deny;
    logic                       accept;

    reg_sel_e                   sel_q;
    logic                       wr_q;
    logic                       rd_q;          // Accepted read in flight
    logic [`SD_DATA_W-1:0]      wdata_q;

    // ========================================
    // Address decode and access rules
    // ========================================
    always_comb begin
        case (reg_addr)
            `SD_CTRL_ADDR:     sel_d = SEL_CTRL;
            `SD_STATUS_ADDR:   sel_d = SEL_STATUS;
            `SD_CMD_ADDR:      sel_d = SEL_CMD;
            `SD_ARG_ADDR:      sel_d = SEL_ARG;
            `SD_RESP0_ADDR:    sel_d = SEL_RESP0;
            `SD_RESP1_ADDR:    sel_d = SEL_RESP1;
            `SD_CLK_DIV_ADDR:  sel_d = SEL_CLK_DIV;
            `SD_INT_EN_ADDR:   sel_d = SEL_INT_EN;
            `SD_INT_STAT_ADDR: sel_d = SEL_INT_STAT;
            `SD_SEC_CTRL_ADDR: sel_d = SEL_SEC_CTRL;
            `SD_VERSION_ADDR:  sel_d = SEL_VERSION;
            default:           sel_d = SEL_NONE;
        endcase
    end

    assign read_only = sel_d inside {SEL_STATUS, SEL_RESP0, SEL_RESP1,
                                     SEL_INT_STAT, SEL_VERSION};
    assign req       = reg_read | reg_write;
    assign deny      = req & ((sel_d == SEL_SEC_CTRL & ~access_granted) |
                              (reg_write & read_only));
    assign accept    = req & (sel_d != SEL_NONE) & ~deny;   // Unmapped gets no answer

    // ========================================
    // Request stage
    // ========================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            sel_q     <= SEL_NONE;
            wr_q      <= 1'b0;
            rd_q      <= 1'b0;
            reg_ready <= 1'b0;
            reg_error <= 1'b0;
        end else begin
            sel_q     <= req ? sel_d : SEL_NONE;
            wr_q      <= accept & reg_write;
            rd_q      <= accept & reg_read;
            reg_ready <= accept;
            reg_error <= deny;
        end
    end

    always_ff @(posedge PCLK_i) begin
        if (reg_write) begin
            wdata_q <= reg_wdata;                 // Payload only
        end
    end

    assign acc = '{sel: sel_q, wr: wr_q, wdata: wdata_q};

    // Blocks return zero for foreign selects, so a plain OR merges them
    assign reg_rdata = rd_q ? (ctrl_rdata | status_rdata) : '0;

    // ========================================
    // Checks
    // ========================================
    a_resp_onehot: assert property (
        @(posedge PCLK_i) disable iff (!PRESETn_i)
        !(reg_ready && reg_error)
    );

    // A write reaching the blocks must never target a read-only register
    a_wr_not_ro: assert property (
        @(posedge PCLK_i) disable iff (!PRESETn_i)
        acc.wr |-> !(acc.sel inside {SEL_STATUS, SEL_RESP0, SEL_RESP1,
                                     SEL_INT_STAT, SEL_VERSION, SEL_NONE})
    );

endmodule

`default_nettype wire

//--- src/sd_reg_top.sv
/*
 * SD host register block top
 * Joins the bus front end with the control and status registers
 */

`timescale 1ns/1ps
`default_nettype none

`include "sd_reg_defs.svh"

module sd_reg_top (
    input  wire logic                           PCLK_i,
    input  wire logic                           PRESETn_i,
    // Register bus
    input  wire logic [`SD_ADDR_W-1:0]          reg_addr,
    input  wire logic [`SD_DATA_W-1:0]          reg_wdata,
    input  wire logic                           reg_read,
    input  wire logic                           reg_write,
    output logic [`SD_DATA_W-1:0]               reg_rdata,
    output logic                                reg_ready,
    output logic                                reg_error,
    // Security
    input  wire logic                           access_granted,
    output logic                                security_lock,
    // Command engine and clock generator
    input  wire sd_link_pkg::cmd_status_t       cmd_status,
    input  wire logic                           clk_calibrated,
    output sd_link_pkg::cmd_ctrl_t              cmd_ctrl,
    output sd_link_pkg::clk_ctrl_t              clk_ctrl,
    // Interrupts
    input  wire logic [`SD_INT_W-1:0]           interrupt_status,
    output logic [`SD_INT_W-1:0]                interrupt_enable,
    output logic [`SD_INT_W-1:0]                interrupt_pending
);

    import sd_regmap_pkg::*;

    reg_access_t                acc;            // Captured request
    logic [`SD_DATA_W-1:0]      ctrl_rdata;
    logic [`SD_DATA_W-1:0]      status_rdata;

    sd_reg_access i_sd_reg_access (
        .PCLK_i         (PCLK_i),
        .PRESETn_i      (PRESETn_i),
        .reg_addr       (reg_addr),
        .reg_wdata      (reg_wdata),
        .reg_read       (reg_read),
        .reg_write      (reg_write),
        .access_granted (access_granted),
        .ctrl_rdata     (ctrl_rdata),
        .status_rdata   (status_rdata),
        .acc            (acc),
        .reg_rdata      (reg_rdata),
        .reg_ready      (reg_ready),
        .reg_error      (reg_error)
    );

    sd_ctrl_regs i_sd_ctrl_regs (
        .PCLK_i           (PCLK_i),
        .PRESETn_i        (PRESETn_i),
        .acc              (acc),
        .rdata            (ctrl_rdata),
        .cmd_ctrl         (cmd_ctrl),
        .clk_ctrl         (clk_ctrl),
        .interrupt_enable (interrupt_enable),
        .security_lock    (security_lock)
    );

    sd_status_regs i_sd_status_regs (
        .PCLK_i            (PCLK_i),
        .PRESETn_i         (PRESETn_i),
        .acc               (acc),
        .cmd_status        (cmd_status),
        .clk_calibrated    (clk_calibrated),
        .interrupt_status  (interrupt_status),
        .rdata             (status_rdata),
        .interrupt_pending (interrupt_pending)
    );

endmodule

`default_nettype wire

//--- src/sd_regmap_pkg.sv
/*
 * SD register map types
 * Register select, decoded access bus and status word layout
 */

`default_nettype none

`include "sd_reg_defs.svh"

package sd_regmap_pkg;

    // One select per mapped register
    typedef enum logic [3:0] {
        SEL_CTRL,
        SEL_STATUS,
        SEL_CMD,
        SEL_ARG,
        SEL_RESP0,
        SEL_RESP1,
        SEL_CLK_DIV,
        SEL_INT_EN,
        SEL_INT_STAT,
        SEL_SEC_CTRL,
        SEL_VERSION,
        SEL_NONE                                // Unmapped address
    } reg_sel_e;

    // Captured request, as seen by the register blocks
    typedef struct packed {
        reg_sel_e                   sel;        // Register in flight
        logic                       wr;         // Write already permitted
        logic [`SD_DATA_W-1:0]      wdata;
    } reg_access_t;

    // STATUS register layout
    typedef struct packed {
        logic [31:14]               rsvd_hi;
        logic                       cmd_busy;   // [13]
        logic                       cmd_done;   // [12]
        logic                       cmd_timeout;    // [11]
        logic                       cmd_crc_error;  // [10]
        logic [9:2]                 rsvd_mid;
        logic                       clk_calibrated; // [1]
        logic                       rsvd_lo;    // [0]
    } status_word_t;

endpackage

`default_nettype wire

//--- src/sd_status_regs.sv
/*
 * SD status registers
 * Per-cycle status and interrupt snapshots, response capture on
 * command done, and the constant version word
 */

`timescale 1ns/1ps
`default_nettype none

`include "sd_reg_defs.svh"

module sd_status_regs (
    input  wire logic                           PCLK_i,
    input  wire logic                           PRESETn_i,
    input  wire sd_regmap_pkg::reg_access_t     acc,
    input  wire sd_link_pkg::cmd_status_t       cmd_status,
    input  wire logic                           clk_calibrated,
    input  wire logic [`SD_INT_W-1:0]           interrupt_status,
    output logic [`SD_DATA_W-1:0]               rdata,
    output logic [`SD_INT_W-1:0]                interrupt_pending
);

    import sd_regmap_pkg::*;

    status_word_t               status_d;
    status_word_t               status_q;
    logic [`SD_INT_W-1:0]       int_stat_q;
    logic [`SD_DATA_W-1:0]      resp0_q;
    logic [`SD_DATA_W-1:0]      resp1_q;

    always_comb begin
        status_d                = '0;
        status_d.cmd_busy       = cmd_status.busy;
        status_d.cmd_done       = cmd_status.done;
        status_d.cmd_timeout    = cmd_status.timeout;
        status_d.cmd_crc_error  = cmd_status.crc_error;
        status_d.clk_calibrated = clk_calibrated;
    end

    // ========================================
    // Snapshots and response capture
    // ========================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            status_q   <= '0;
            int_stat_q <= '0;
            resp0_q    <= '0;
            resp1_q    <= '0;
        end else begin
            status_q   <= status_d;             // Sampled every cycle
            int_stat_q <= interrupt_status;
            if (cmd_status.done) begin
                resp0_q <= {8'h00, cmd_status.response[39:16]};
                resp1_q <= {cmd_status.response[15:0], 16'h0000};
            end
        end
    end

    assign interrupt_pending = int_stat_q;      // One cycle behind the input

    // ========================================
    // Read-back
    // ========================================
    always_comb begin
        case (acc.sel)
            SEL_STATUS:   rdata = status_q;
            SEL_RESP0:    rdata = resp0_q;
            SEL_RESP1:    rdata = resp1_q;
            SEL_INT_STAT: rdata = {{(`SD_DATA_W-`SD_INT_W){1'b0}}, int_stat_q};
            SEL_VERSION:  rdata = `SD_VERSION_VAL;
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire
